/* filelist.f */
frontend_pkg.sv
frontend_ifs.sv
prefetch.sv
prefetch_fifo.sv
immediate_reader.sv
modrm_decode.sv
decode_control.sv
frontend_top.sv
tb_frontend.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_frontend
FILELIST  = filelist.f
LOG       = sim.log
PASS_MSG  = Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_frontend.sv */
module tb_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int insns_total = 130;
    localparam int cycle_limit = 200 * insns_total + 1000;

    logic        clk;
    logic        rst_n;
    logic [15:0] instr_m_data_in;
    logic        instr_m_ack;
    logic        load_new_ip;
    logic [15:0] new_cs;
    logic [15:0] new_ip;
    logic        next_instruction;
    logic [19:1] instr_m_addr;
    logic        instr_m_access;
    logic        insn_valid;
    logic [7:0]  insn_opcode;
    logic        insn_has_modrm;
    logic [7:0]  insn_modrm;
    logic [15:0] insn_disp;
    logic [15:0] insn_imm;
    logic [2:0]  insn_length;

    logic [7:0]  mem [0:1048575];
    int          wait_cnt;
    int          cycles;
    int          errors;
    int          checks;
    int          tests;
    string       cur_test;

    frontend_top uut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles in test %s", cycles, cur_test);
            $display("Something failed");
            $finish;
        end
    end

    // Bus slave with 0 to 3 wait cycles per word
    always @(posedge clk) begin
        instr_m_ack <= 1'b0;
        if (instr_m_access && !instr_m_ack) begin
            if (wait_cnt == 0) begin
                instr_m_ack <= 1'b1;
                instr_m_data_in <= {mem[{instr_m_addr, 1'b1}], mem[{instr_m_addr, 1'b0}]};
                wait_cnt <= $urandom % 4;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    // 0 plain, 1 imm8, 2 imm16, 3 modrm, 4 modrm+imm8, 5 modrm+imm16
    function automatic int op_class(logic [7:0] op);
        if ((op >= 8'hb0 && op <= 8'hb7) || op == 8'h04) return 1;
        if ((op >= 8'hb8 && op <= 8'hbf) || op == 8'h05) return 2;
        if (op >= 8'h88 && op <= 8'h8b) return 3;
        if (op == 8'h80 || op == 8'h83) return 4;
        if (op == 8'h81 || op == 8'hc7) return 5;
        return 0;
    endfunction

    function automatic void ref_decode(input int pos, output logic [7:0] op,
                                       output logic hm, output logic [7:0] mrm,
                                       output logic [15:0] disp, output logic [15:0] imm,
                                       output logic [2:0] len);
        int p;
        int c;
        logic [1:0] md;
        p = pos;
        op = mem[p];
        p++;
        c = op_class(op);
        hm = c >= 3;
        mrm = '0;
        disp = '0;
        imm = '0;
        if (hm) begin
            mrm = mem[p];
            p++;
            md = mrm[7:6];
            if (md == 2'b01) begin
                disp = {{8{mem[p][7]}}, mem[p]};
                p++;
            end else if (md == 2'b10 || (md == 2'b00 && mrm[2:0] == 3'b110)) begin
                disp = {mem[p + 1], mem[p]};
                p += 2;
            end
        end
        if (c == 1 || c == 4) begin
            imm = {8'h00, mem[p]};
            p++;
        end else if (c == 2 || c == 5) begin
            imm = {mem[p + 1], mem[p]};
            p += 2;
        end
        len = 3'(p - pos);
    endfunction

    function automatic logic [7:0] pick_opcode(int c);
        logic [7:0] op;
        case (c)
            1: op = ($urandom % 2) ? (8'hb0 | 8'($urandom % 8)) : 8'h04;
            2: op = ($urandom % 2) ? (8'hb8 | 8'($urandom % 8)) : 8'h05;
            3: op = 8'h88 | 8'($urandom % 4);
            4: op = ($urandom % 2) ? 8'h80 : 8'h83;
            5: op = ($urandom % 2) ? 8'h81 : 8'hc7;
            default: begin
                op = 8'($urandom);
                while (op_class(op) != 0) begin
                    op = 8'($urandom);
                end
            end
        endcase
        return op;
    endfunction

    // mode 0 no ModRM, 1 ModRM only, 2 everything
    task automatic gen_stream(input int base, input int n, input int mode);
        int p;
        int c;
        int k;
        logic [7:0] mrm;
        p = base;
        for (k = 0; k < n; k++) begin
            c = (mode == 0) ? $urandom % 3 : (mode == 1) ? 3 + $urandom % 3 : $urandom % 6;
            mem[p] = pick_opcode(c);
            p++;
            if (c >= 3) begin
                mrm = 8'($urandom);
                // Walk through all four mod values, then the direct address form
                if (k < 4) mrm[7:6] = 2'(k);
                if (k % 5 == 4) mrm = {2'b00, mrm[5:3], 3'b110};
                mem[p] = mrm;
                p++;
                repeat (4) begin
                    mem[p] = 8'($urandom);
                    p++;
                end
                p -= 4;
                if (mrm[7:6] == 2'b01) p += 1;
                else if (mrm[7:6] == 2'b10 || mrm[2:0] == 3'b110 && mrm[7:6] == 2'b00) p += 2;
            end
            repeat (2) begin
                mem[p] = 8'($urandom);
                p++;
            end
            p -= 2;
            if (c == 1 || c == 4) p += 1;
            else if (c == 2 || c == 5) p += 2;
        end
    endtask

    task automatic report_value(string field, logic [19:0] exp, logic [19:0] act);
        errors++;
        $display("[ERROR] %s %s: expected %h, actual %h", cur_test, field, exp, act);
    endtask

    task automatic wait_valid();
        do @(negedge clk); while (!insn_valid);
    endtask

    task automatic release_insn();
        @(posedge clk);
        repeat ($urandom % 5) @(posedge clk);
        next_instruction <= 1'b1;
        @(posedge clk);
        next_instruction <= 1'b0;
    endtask

    task automatic redirect(input logic [15:0] cs, input logic [15:0] ip);
        @(posedge clk);
        load_new_ip <= 1'b1;
        new_cs <= cs;
        new_ip <= ip;
        @(posedge clk);
        load_new_ip <= 1'b0;
    endtask

    task automatic hold_check();
        logic [51:0] rec;
        rec = {insn_opcode, insn_has_modrm, insn_modrm, insn_disp, insn_imm, insn_length};
        repeat (60) begin
            @(negedge clk);
            if (!insn_valid ||
                rec !== {insn_opcode, insn_has_modrm, insn_modrm, insn_disp, insn_imm,
                         insn_length}) begin
                errors++;
                $display("Record in %s changed while held", cur_test);
            end
        end
        checks++;
        if (instr_m_access) begin
            errors++;
            $display("Prefetch in %s kept fetching under back-pressure", cur_test);
        end
    endtask

    task automatic check_stream(input int base, input int n, input int hold_at);
        int pos;
        int i;
        logic [7:0]  e_op;
        logic        e_hm;
        logic [7:0]  e_mrm;
        logic [15:0] e_disp;
        logic [15:0] e_imm;
        logic [2:0]  e_len;
        pos = base;
        for (i = 0; i < n; i++) begin
            wait_valid();
            ref_decode(pos, e_op, e_hm, e_mrm, e_disp, e_imm, e_len);
            checks++;
            if (insn_opcode !== e_op) report_value("opcode", 16'(e_op), 16'(insn_opcode));
            if (insn_has_modrm !== e_hm) report_value("has_modrm", 16'(e_hm), 16'(insn_has_modrm));
            if (e_hm && insn_modrm !== e_mrm) report_value("modrm", 16'(e_mrm), 16'(insn_modrm));
            if (insn_disp !== e_disp) report_value("disp", e_disp, insn_disp);
            if (insn_imm !== e_imm) report_value("imm", e_imm, insn_imm);
            if (insn_length !== e_len) report_value("length", 16'(e_len), 16'(insn_length));
            if (i == hold_at) hold_check();
            pos += e_len;
            release_insn();
        end
    endtask

    task automatic end_test(input int errs_before);
        tests++;
        $display("test %s: %0s (%0d errors)", cur_test,
                 (errors == errs_before) ? "passed" : "failed", errors - errs_before);
    endtask

    initial begin
        int e;
        int i;
        logic prev;
        void'($urandom(44));
        clk = 1'b0;
        rst_n = 1'b0;
        instr_m_data_in = '0;
        instr_m_ack = 1'b0;
        load_new_ip = 1'b0;
        new_cs = '0;
        new_ip = '0;
        next_instruction = 1'b0;
        wait_cnt = 0;
        cycles = 0;
        errors = 0;
        checks = 0;
        tests = 0;
        cur_test = "reset";
        for (i = 0; i < 1048576; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16);
        end
        gen_stream(32'h00000, 30, 0);
        gen_stream(32'h10100, 30, 1);
        gen_stream(32'h23463, 20, 2);
        gen_stream(32'h09000, 20, 2);
        gen_stream(32'h30000, 30, 2);

        e = errors;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        if (instr_m_access || insn_valid) begin
            errors++;
            $display("Access or valid high right after reset");
        end
        do @(negedge clk); while (!instr_m_access);
        checks++;
        if (instr_m_addr !== 19'h0) report_value("fetch addr", 20'h0, 20'(instr_m_addr));
        end_test(e);

        cur_test = "plain_imm";
        e = errors;
        check_stream(32'h00000, 30, -1);
        end_test(e);

        cur_test = "modrm";
        e = errors;
        redirect(16'h1000, 16'h0100);
        check_stream(32'h10100, 30, -1);
        end_test(e);

        cur_test = "odd_redirect";
        e = errors;
        redirect(16'h2345, 16'h0013);
        prev = 1'b1;
        forever begin
            @(negedge clk);
            if (instr_m_access && !prev) break;
            prev = instr_m_access;
        end
        checks++;
        if (instr_m_addr !== 19'(32'h23463 >> 1)) begin
            report_value("fetch addr", 20'(32'h23463 >> 1), 20'(instr_m_addr));
        end
        check_stream(32'h23463, 20, -1);
        end_test(e);

        cur_test = "mid_redirect";
        e = errors;
        wait_valid();
        // Move on until a record is held while a fetch is in flight
        while (!(instr_m_access && !instr_m_ack)) begin
            release_insn();
            wait_valid();
        end
        redirect(16'h0000, 16'h9000);
        @(negedge clk);
        checks++;
        if (insn_valid) begin
            errors++;
            $display("Record still valid after redirect in %s", cur_test);
        end
        check_stream(32'h09000, 20, -1);
        end_test(e);

        cur_test = "backpressure";
        e = errors;
        redirect(16'h3000, 16'h0000);
        check_stream(32'h30000, 30, 3);
        end_test(e);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* frontend_top.sv */
module frontend_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] instr_m_data_in,
    input  logic        instr_m_ack,
    input  logic        load_new_ip,
    input  logic [15:0] new_cs,
    input  logic [15:0] new_ip,
    input  logic        next_instruction,
    output logic [19:1] instr_m_addr,
    output logic        instr_m_access,
    output logic        insn_valid,
    output logic [7:0]  insn_opcode,
    output logic        insn_has_modrm,
    output logic [7:0]  insn_modrm,
    output logic [15:0] insn_disp,
    output logic [15:0] insn_imm,
    output logic [2:0]  insn_length
);
    logic       fifo_wr_en;
    logic [7:0] fifo_wr_data;
    logic       fifo_flush;
    logic       fifo_rd_en;
    logic [7:0] fifo_rd_data;
    logic       fifo_empty;
    logic       fifo_nearly_full;
    logic       dc_rd_en;
    logic       imm_rd_en;
    logic       mr_rd_en;

    immed_if imm_bus ();
    modrm_if mr_bus ();

    assign fifo_rd_en = dc_rd_en | imm_rd_en | mr_rd_en;

    prefetch u_prefetch (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_new_ip      (load_new_ip),
        .new_cs           (new_cs),
        .new_ip           (new_ip),
        .fifo_nearly_full (fifo_nearly_full),
        .instr_m_data_in  (instr_m_data_in),
        .instr_m_ack      (instr_m_ack),
        .instr_m_addr     (instr_m_addr),
        .instr_m_access   (instr_m_access),
        .fifo_wr_en       (fifo_wr_en),
        .fifo_wr_data     (fifo_wr_data),
        .fifo_flush       (fifo_flush)
    );

    prefetch_fifo u_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (fifo_flush),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .empty       (fifo_empty),
        .nearly_full (fifo_nearly_full)
    );

    decode_control u_decode (
        .clk              (clk),
        .rst_n            (rst_n),
        .load_new_ip      (load_new_ip),
        .next_instruction (next_instruction),
        .fifo_rd_data     (fifo_rd_data),
        .fifo_empty       (fifo_empty),
        .fifo_rd_en       (dc_rd_en),
        .insn_valid       (insn_valid),
        .insn_opcode      (insn_opcode),
        .insn_has_modrm   (insn_has_modrm),
        .insn_modrm       (insn_modrm),
        .insn_disp        (insn_disp),
        .insn_imm         (insn_imm),
        .insn_length      (insn_length),
        .imm              (imm_bus.controller),
        .mr               (mr_bus.controller)
    );

    immediate_reader u_imm (
        .clk          (clk),
        .rst_n        (rst_n),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (imm_rd_en),
        .imm          (imm_bus.target)
    );

    modrm_decode u_modrm (
        .clk          (clk),
        .rst_n        (rst_n),
        .fifo_rd_data (fifo_rd_data),
        .fifo_empty   (fifo_empty),
        .fifo_rd_en   (mr_rd_en),
        .mr           (mr_bus.target)
    );

endmodule

/* decode_control.sv */
module decode_control (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_new_ip,
    input  logic        next_instruction,
    input  logic [7:0]  fifo_rd_data,
    input  logic        fifo_empty,
    output logic        fifo_rd_en,
    output logic        insn_valid,
    output logic [7:0]  insn_opcode,
    output logic        insn_has_modrm,
    output logic [7:0]  insn_modrm,
    output logic [15:0] insn_disp,
    output logic [15:0] insn_imm,
    output logic [2:0]  insn_length,
    immed_if.controller imm,
    modrm_if.controller mr
);
    import frontend_pkg::*;

    logic [1:0] state;
    opclass_t   cls;
    opclass_t   cur_cls;
    logic       imm_start_q;
    logic       mr_start_q;

    function automatic opclass_t classify(logic [7:0] op);
        if (op[7:3] == 5'b10110 || op == 8'h04) return oc_imm8;
        if (op[7:3] == 5'b10111 || op == 8'h05) return oc_imm16;
        if (op[7:2] == 6'b100010) return oc_modrm;
        if (op == 8'h80 || op == 8'h83) return oc_modrm_imm8;
        if (op == 8'h81 || op == 8'hc7) return oc_modrm_imm16;
        return oc_plain;
    endfunction

    assign cur_cls = classify(fifo_rd_data);
    assign fifo_rd_en = state == st_opcode;
    assign imm.start = imm_start_q;
    assign imm.abort = load_new_ip;
    assign imm.is_8bit = cls == oc_imm8 || cls == oc_modrm_imm8;
    assign mr.start = mr_start_q;
    assign mr.abort = load_new_ip;
    assign insn_has_modrm = cls inside {oc_modrm, oc_modrm_imm8, oc_modrm_imm16};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_opcode;
            cls <= oc_plain;
            insn_valid <= 1'b0;
            imm_start_q <= 1'b0;
            mr_start_q <= 1'b0;
        end else begin
            imm_start_q <= 1'b0;
            mr_start_q <= 1'b0;
            if (load_new_ip) begin
                state <= st_opcode;
                insn_valid <= 1'b0;
            end else begin
                case (state)
                    st_opcode: if (!fifo_empty) begin
                        cls <= cur_cls;
                        if (cur_cls inside {oc_modrm, oc_modrm_imm8, oc_modrm_imm16}) begin
                            mr_start_q <= 1'b1;
                            state <= st_modrm;
                        end else if (cur_cls != oc_plain) begin
                            imm_start_q <= 1'b1;
                            state <= st_imm;
                        end else begin
                            insn_valid <= 1'b1;
                            state <= st_hold;
                        end
                    end
                    st_modrm: if (mr.complete) begin
                        // Immediate follows the displacement
                        if (cls != oc_modrm) begin
                            imm_start_q <= 1'b1;
                            state <= st_imm;
                        end else begin
                            insn_valid <= 1'b1;
                            state <= st_hold;
                        end
                    end
                    st_imm: if (imm.complete) begin
                        insn_valid <= 1'b1;
                        state <= st_hold;
                    end
                    default: if (next_instruction) begin
                        insn_valid <= 1'b0;
                        state <= st_opcode;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_opcode && !fifo_empty) begin
            insn_opcode <= fifo_rd_data;
            insn_modrm <= '0;
            insn_disp <= '0;
            insn_imm <= '0;
            insn_length <= 3'd1;
        end else if (state == st_modrm && mr.complete) begin
            insn_modrm <= mr.modrm;
            insn_disp <= mr.disp;
            insn_length <= insn_length + 3'd1 + {1'b0, disp_len(mr.modrm)};
        end else if (state == st_imm && imm.complete) begin
            insn_imm <= imm.immediate;
            insn_length <= insn_length + (imm.is_8bit ? 3'd1 : 3'd2);
        end
    end

    // Only one reader may own the FIFO read port
    assert property (@(posedge clk) disable iff (!rst_n)
        !((imm.start || imm.busy) && (mr.start || mr.busy)));

    assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd_en |-> !imm.busy && !mr.busy);

endmodule

/* modrm_decode.sv */
module modrm_decode (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] fifo_rd_data,
    input  logic       fifo_empty,
    output logic       fifo_rd_en,
    modrm_if.target    mr
);
    import frontend_pkg::*;

    logic        active;
    logic        got_modrm;
    logic        disp8;
    logic [1:0]  disp_left;
    logic [1:0]  need;
    logic        complete_q;
    modrm_t      modrm_q;
    logic [15:0] disp_q;
    logic        take;

    assign take = active & ~fifo_empty;
    assign need = disp_len(fifo_rd_data);
    assign fifo_rd_en = active;
    assign mr.busy = active;
    assign mr.complete = complete_q;
    assign mr.modrm = modrm_q;
    assign mr.disp = disp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            got_modrm <= 1'b0;
            disp8 <= 1'b0;
            disp_left <= '0;
            complete_q <= 1'b0;
        end else if (mr.abort) begin
            active <= 1'b0;
            complete_q <= 1'b0;
        end else begin
            complete_q <= 1'b0;
            if (mr.start) begin
                active <= 1'b1;
                got_modrm <= 1'b0;
            end else if (take && !got_modrm) begin
                got_modrm <= 1'b1;
                disp_left <= need;
                disp8 <= need == 2'd1;
                if (need == 2'd0) begin
                    active <= 1'b0;
                    complete_q <= 1'b1;
                end
            end else if (take) begin
                disp_left <= disp_left - 2'd1;
                if (disp_left == 2'd1) begin
                    active <= 1'b0;
                    complete_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && !got_modrm) begin
            modrm_q <= fifo_rd_data;
            disp_q <= '0;
        end else if (take) begin
            if (disp8) begin
                disp_q <= {{8{fifo_rd_data[7]}}, fifo_rd_data};
            end else if (disp_left == 2'd2) begin
                disp_q[7:0] <= fifo_rd_data;
            end else begin
                disp_q[15:8] <= fifo_rd_data;
            end
        end
    end

endmodule

/* immediate_reader.sv */
module immediate_reader (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] fifo_rd_data,
    input  logic       fifo_empty,
    output logic       fifo_rd_en,
    immed_if.target    imm
);
    logic        active;
    logic        second;
    logic        is_8bit_q;
    logic        complete_q;
    logic [15:0] value;
    logic        take;

    assign take = active & ~fifo_empty;
    assign fifo_rd_en = active;
    assign imm.busy = active;
    assign imm.complete = complete_q;
    assign imm.immediate = value;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            second <= 1'b0;
            is_8bit_q <= 1'b0;
            complete_q <= 1'b0;
        end else if (imm.abort) begin
            active <= 1'b0;
            second <= 1'b0;
            complete_q <= 1'b0;
        end else begin
            complete_q <= 1'b0;
            if (imm.start) begin
                active <= 1'b1;
                second <= 1'b0;
                is_8bit_q <= imm.is_8bit;
            end else if (take) begin
                second <= 1'b1;
                if (second || is_8bit_q) begin
                    active <= 1'b0;
                    complete_q <= 1'b1;
                end
            end
        end
    end

    // Little-endian, imm8 left zero-extended
    always_ff @(posedge clk) begin
        if (imm.start) begin
            value <= '0;
        end else if (take) begin
            if (second) begin
                value[15:8] <= fifo_rd_data;
            end else begin
                value[7:0] <= fifo_rd_data;
            end
        end
    end

endmodule

/* prefetch_fifo.sv */
module prefetch_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,
    input  logic       wr_en,
    input  logic [7:0] wr_data,
    input  logic       rd_en,
    output logic [7:0] rd_data,
    output logic       empty,
    output logic       nearly_full
);
    import frontend_pkg::*;

    logic [7:0]                      mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(fifo_depth+1)-1:0] count;
    logic                            do_rd;

    assign do_rd = rd_en & ~empty;
    assign empty = count == '0;
    assign nearly_full = count >= fifo_nearly_full_level;
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == fifo_depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == fifo_depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && !flush) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && !flush |-> count < fifo_depth);

endmodule

/* prefetch.sv */
module prefetch (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_new_ip,
    input  logic [15:0] new_cs,
    input  logic [15:0] new_ip,
    input  logic        fifo_nearly_full,
    input  logic [15:0] instr_m_data_in,
    input  logic        instr_m_ack,
    output logic [19:1] instr_m_addr,
    output logic        instr_m_access,
    output logic        fifo_wr_en,
    output logic [7:0]  fifo_wr_data,
    output logic        fifo_flush
);
    import frontend_pkg::*;

    logic [15:0] fetch_cs;
    logic [15:0] fetch_ip;
    logic [19:0] linear;
    logic        pending_hi;
    logic [7:0]  hi_byte;
    logic        discard;
    logic        take;
    fetch_word_t word;

    assign linear = {fetch_cs, 4'h0} + {4'h0, fetch_ip};
    assign word.word = instr_m_data_in;

    // Ack for a word that still belongs to the current stream
    assign take = instr_m_access & instr_m_ack & ~discard & ~load_new_ip;

    assign fifo_flush = load_new_ip;
    assign fifo_wr_en = take | (pending_hi & ~load_new_ip);
    assign fifo_wr_data = pending_hi ? hi_byte :
                          fetch_ip[0] ? word.bytes.hi : word.bytes.lo;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cs <= '0;
            fetch_ip <= '0;
            instr_m_addr <= '0;
            instr_m_access <= 1'b0;
            pending_hi <= 1'b0;
            discard <= 1'b0;
        end else if (load_new_ip) begin
            fetch_cs <= new_cs;
            fetch_ip <= new_ip;
            pending_hi <= 1'b0;
            // An outstanding fetch still has to finish on the bus
            discard <= instr_m_access & ~instr_m_ack;
            if (instr_m_access && instr_m_ack) begin
                instr_m_access <= 1'b0;
            end
        end else begin
            pending_hi <= 1'b0;
            if (instr_m_access) begin
                if (instr_m_ack) begin
                    instr_m_access <= 1'b0;
                    discard <= 1'b0;
                    if (!discard) begin
                        fetch_ip <= fetch_ip + (fetch_ip[0] ? 16'd1 : 16'd2);
                        pending_hi <= ~fetch_ip[0];
                    end
                end
            end else if (!fifo_nearly_full) begin
                instr_m_access <= 1'b1;
                instr_m_addr <= linear[19:1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            hi_byte <= word.bytes.hi;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        instr_m_access && !instr_m_ack |=> instr_m_access && $stable(instr_m_addr));

endmodule

/* frontend_ifs.sv */
interface immed_if;
    logic        start;
    logic        abort;
    logic        is_8bit;
    logic        busy;
    logic        complete;
    logic [15:0] immediate;

    modport controller (output start, abort, is_8bit, input busy, complete, immediate);
    modport target (input start, abort, is_8bit, output busy, complete, immediate);
endinterface

interface modrm_if;
    import frontend_pkg::*;

    logic        start;
    logic        abort;
    logic        busy;
    logic        complete;
    modrm_t      modrm;
    logic [15:0] disp;

    modport controller (output start, abort, input busy, complete, modrm, disp);
    modport target (input start, abort, output busy, complete, modrm, disp);
endinterface

/* frontend_pkg.sv */
package frontend_pkg;

    localparam int fifo_depth = 6;
    localparam int fifo_nearly_full_level = 4;

    // rm value that selects a direct 16-bit address when mod is 00
    localparam logic [2:0] modrm_disp_none_rm = 3'b110;

    // Decode sequencer states
    localparam logic [1:0] st_opcode = 2'd0;
    localparam logic [1:0] st_modrm = 2'd1;
    localparam logic [1:0] st_imm = 2'd2;
    localparam logic [1:0] st_hold = 2'd3;

    typedef enum logic [2:0] {
        oc_plain,
        oc_imm8,
        oc_imm16,
        oc_modrm,
        oc_modrm_imm8,
        oc_modrm_imm16
    } opclass_t;

    // Bus side sees the whole word, FIFO write path picks bytes
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } fetch_word_t;

    typedef struct packed {
        logic [1:0] mod;
        logic [2:0] reg_f;
        logic [2:0] rm;
    } modrm_t;

    // Number of displacement bytes after a ModRM byte
    function automatic logic [1:0] disp_len(modrm_t m);
        case (m.mod)
            2'b00: return (m.rm == modrm_disp_none_rm) ? 2'd2 : 2'd0;
            2'b01: return 2'd1;
            2'b10: return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

endpackage
